// File: include/atari_defs.svh
// width, Wishbone register map and status bit positions, included by hw and bench files
`ifndef ATARI_DEFS_SVH
`define ATARI_DEFS_SVH

// datapath width
`define DATA_W 8

// Wishbone word addresses
`define ADR_A    3'd0
`define ADR_X    3'd1
`define ADR_Y    3'd2
`define ADR_S    3'd3
`define ADR_P    3'd4
`define ADR_OPND 3'd5
`define ADR_CMD  3'd6

// NV-BDIZC bit positions, bit 5 is always one
`define STATUS_C 0
`define STATUS_Z 1
`define STATUS_I 2
`define STATUS_D 3
`define STATUS_B 4
`define STATUS_V 6
`define STATUS_N 7

`endif

// File: hw/atariCorePkg.sv
// shared types of the execution unit, referenced by scoped name from the RTL and the testbench
package atariCorePkg;

    // command byte values 0 to 9 select an operation
    // any other byte decodes to opNop
    typedef enum logic [3:0] {
        opAdc = 4'h0,
        opSbc = 4'h1,
        opAnd = 4'h2,
        opOra = 4'h3,
        opEor = 4'h4,
        opLsr = 4'h5,
        opInx = 4'h6,
        opIny = 4'h7,
        opTax = 4'h8,
        opTxa = 4'h9,
        opNop = 4'hf
    } opT;

    // one ALU or decimal adjust result with its flag outputs
    typedef struct packed {
        logic [7:0] value;
        logic       carry;
        logic       halfCarry;
        logic       overflow;
    } aluResultT;

    // register written back at the end of a command
    typedef enum logic [1:0] {
        selNone = 2'd0,
        selA    = 2'd1,
        selX    = 2'd2,
        selY    = 2'd3
    } regSelT;

endpackage

// File: hw/holdLatch.sv
// load-enabled register for any payload type, used as operand latch and adder hold register
`timescale 1ns/1ps

module holdLatch #(
    parameter type payloadT = logic [7:0]
) (
    input  logic    phi2,
    input  logic    arstN,
    input  logic    load,
    input  payloadT d,
    output payloadT q
);

    // keeps its value until the next load
    always_ff @(posedge phi2 or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (load) begin
            q <= d;
        end
    end

endmodule

// File: hw/aluCore.sv
// combinational binary ALU of the execution unit, feeds the adder hold register
`timescale 1ns/1ps
`include "atari_defs.svh"

module aluCore (
    input  logic [`DATA_W-1:0]      a,
    input  logic [`DATA_W-1:0]      b,
    input  logic                    carryIn,
    input  atariCorePkg::opT        aluOp,
    output atariCorePkg::aluResultT result
);

    logic [`DATA_W-1:0] bOp;
    logic [4:0]         loSum;
    logic [4:0]         hiSum;
    logic [`DATA_W:0]   incSum;

    // subtract is a + ~b + c, so C set means no borrow
    assign bOp = (aluOp == atariCorePkg::opSbc) ? ~b : b;

    // low nibble first, its carry out is the half-carry
    assign loSum = {1'b0, a[3:0]} + {1'b0, bOp[3:0]} + {4'd0, carryIn};
    assign hiSum = {1'b0, a[7:4]} + {1'b0, bOp[7:4]} + {4'd0, loSum[4]};

    // INX and INY ignore the carry input
    assign incSum = {1'b0, a} + 9'd1;

    always_comb begin
        result = '0;
        case (aluOp)
            atariCorePkg::opAdc, atariCorePkg::opSbc: begin
                result.value     = {hiSum[3:0], loSum[3:0]};
                result.carry     = hiSum[4];
                result.halfCarry = loSum[4];
                // same input signs but a different result sign
                result.overflow  = (a[7] == bOp[7]) && (hiSum[3] != a[7]);
            end
            atariCorePkg::opAnd: result.value = a & b;
            atariCorePkg::opOra: result.value = a | b;
            atariCorePkg::opEor: result.value = a ^ b;
            atariCorePkg::opLsr: begin
                // bit 0 falls out into carry
                result.value = {1'b0, a[7:1]};
                result.carry = a[0];
            end
            atariCorePkg::opInx, atariCorePkg::opIny: begin
                result.value = incSum[`DATA_W-1:0];
                result.carry = incSum[`DATA_W];
            end
            // transfers and NOP pass a through
            default: result.value = a;
        endcase
    end

endmodule

// File: hw/decimalAdjust.sv
// registered BCD correction stage between the adder hold register and writeback
`timescale 1ns/1ps

module decimalAdjust (
    input  logic                    phi2,
    input  logic                    arstN,
    input  atariCorePkg::aluResultT held,
    input  atariCorePkg::opT        aluOp,
    input  logic                    decimalEn,
    output atariCorePkg::aluResultT adjusted
);

    atariCorePkg::aluResultT nextAdj;

    always_comb begin
        // binary result and overflow pass by default
        nextAdj = held;
        if (decimalEn && aluOp == atariCorePkg::opAdc) begin
            // low digit out of range or carried into the high digit
            if (held.value[3:0] > 4'd9 || held.halfCarry) begin
                nextAdj.value = nextAdj.value + 8'h06;
            end
            // high digit overflow gives the decimal carry
            if (held.carry || held.value > 8'h99) begin
                nextAdj.value = nextAdj.value + 8'h60;
                nextAdj.carry = 1'b1;
            end
        end else if (decimalEn && aluOp == atariCorePkg::opSbc) begin
            // a missing carry is a borrow out of that digit
            if (!held.halfCarry) begin
                nextAdj.value = nextAdj.value - 8'h06;
            end
            if (!held.carry) begin
                nextAdj.value = nextAdj.value - 8'h60;
            end
        end
    end

    always_ff @(posedge phi2 or negedge arstN) begin
        if (!arstN) begin
            adjusted <= '0;
        end else begin
            adjusted <= nextAdj;
        end
    end

endmodule

// File: hw/regBank.sv
// A, X, Y and S registers with ALU operand select, command writeback and host writes
`timescale 1ns/1ps
`include "atari_defs.svh"

module regBank (
    input  logic                 phi2,
    input  logic                 arstN,
    input  atariCorePkg::opT     aluOp,
    input  atariCorePkg::regSelT wbSel,
    input  logic                 regWe,
    input  logic [`DATA_W-1:0]   wbValue,
    input  logic [2:0]           hostRegSel,
    input  logic                 hostWe,
    input  logic [`DATA_W-1:0]   hostData,
    output logic [`DATA_W-1:0]   aluA,
    output logic [`DATA_W-1:0]   regA,
    output logic [`DATA_W-1:0]   regX,
    output logic [`DATA_W-1:0]   regY,
    output logic [`DATA_W-1:0]   regS
);

    // ALU a operand, X for INX and TXA, Y for INY
    always_comb begin
        case (aluOp)
            atariCorePkg::opInx, atariCorePkg::opTxa: aluA = regX;
            atariCorePkg::opIny:                      aluA = regY;
            default:                                  aluA = regA;
        endcase
    end

    always_ff @(posedge phi2 or negedge arstN) begin
        if (!arstN) begin
            regA <= '0;
            regX <= '0;
            regY <= '0;
            // stack pointer starts at the top of page one
            regS <= 8'hff;
        end else if (hostWe) begin
            // host write has priority over writeback
            case (hostRegSel)
                `ADR_A: regA <= hostData;
                `ADR_X: regX <= hostData;
                `ADR_Y: regY <= hostData;
                `ADR_S: regS <= hostData;
                default: ;
            endcase
        end else if (regWe) begin
            case (wbSel)
                atariCorePkg::selA: regA <= wbValue;
                atariCorePkg::selX: regX <= wbValue;
                atariCorePkg::selY: regY <= wbValue;
                default: ;
            endcase
        end
    end

endmodule

// File: hw/statusReg.sv
// NV-BDIZC processor status register, updated by commands and by host writes to P
`timescale 1ns/1ps
`include "atari_defs.svh"

module statusReg (
    input  logic                    phi2,
    input  logic                    arstN,
    input  logic                    flagWe,
    input  atariCorePkg::opT        aluOp,
    input  atariCorePkg::aluResultT adjusted,
    input  logic                    hostWe,
    input  logic [2:0]              hostSel,
    input  logic [`DATA_W-1:0]      hostData,
    output logic [`DATA_W-1:0]      status
);

    // bit 5 and B always read as one
    localparam logic [7:0] fixedBits = 8'h20 | (8'h01 << `STATUS_B);
    // interrupts masked out of reset
    localparam logic [7:0] resetValue = fixedBits | (8'h01 << `STATUS_I);

    logic carryOp;
    logic overflowOp;

    // C for arithmetic and shift, V only for arithmetic
    assign overflowOp = (aluOp == atariCorePkg::opAdc) || (aluOp == atariCorePkg::opSbc);
    assign carryOp    = overflowOp || (aluOp == atariCorePkg::opLsr);

    always_ff @(posedge phi2 or negedge arstN) begin
        if (!arstN) begin
            status <= resetValue;
        end else if (hostWe && hostSel == `ADR_P) begin
            status <= hostData | fixedBits;
        end else if (flagWe) begin
            status[`STATUS_N] <= adjusted.value[7];
            status[`STATUS_Z] <= (adjusted.value == '0);
            if (carryOp) begin
                status[`STATUS_C] <= adjusted.carry;
            end
            if (overflowOp) begin
                status[`STATUS_V] <= adjusted.overflow;
            end
        end
    end

endmodule

// File: hw/execControl.sv
// Wishbone slave decode, command sequencer and read mux of the execution unit
`timescale 1ns/1ps
`include "atari_defs.svh"

module execControl (
    input  logic                 phi2,
    input  logic                 arstN,
    input  logic                 wbCyc,
    input  logic                 wbStb,
    input  logic                 wbWe,
    input  logic [2:0]           wbAdr,
    input  logic [`DATA_W-1:0]   wbDatWr,
    input  logic [`DATA_W-1:0]   regA,
    input  logic [`DATA_W-1:0]   regX,
    input  logic [`DATA_W-1:0]   regY,
    input  logic [`DATA_W-1:0]   regS,
    input  logic [`DATA_W-1:0]   status,
    output logic [`DATA_W-1:0]   wbDatRd,
    output logic                 wbAck,
    output logic                 opndLoad,
    output logic                 holdLoad,
    output atariCorePkg::opT     aluOp,
    output atariCorePkg::regSelT wbSel,
    output logic                 regWe,
    output logic                 flagWe,
    output logic [2:0]           hostRegSel,
    output logic                 hostWe,
    output atariCorePkg::opT     cmdOp
);

    typedef enum logic [1:0] {
        stIdle,
        stAdjust,
        stWrite
    } seqStateT;

    seqStateT         state;
    logic             reqActive;
    logic             regAccess;
    logic             cmdStart;
    atariCorePkg::opT decodedOp;

    // command bytes above 9 run as NOP
    function automatic atariCorePkg::opT decodeOp(input logic [7:0] code);
        atariCorePkg::opT op;
        if (code <= 8'h09) begin
            op = atariCorePkg::opT'(code[3:0]);
        end else begin
            op = atariCorePkg::opNop;
        end
        return op;
    endfunction

    // a new request is one not yet acked
    assign reqActive = wbCyc && wbStb && !wbAck && (state == stIdle);
    assign cmdStart  = reqActive && wbWe && (wbAdr == `ADR_CMD);
    assign regAccess = reqActive && !cmdStart;
    assign decodedOp = decodeOp(wbDatWr);

    // host side strobes take effect on the ack edge
    assign opndLoad   = regAccess && wbWe && (wbAdr == `ADR_OPND);
    assign hostWe     = regAccess && wbWe && (wbAdr != `ADR_OPND);
    assign hostRegSel = wbAdr;

    // ALU sees the command byte before the first edge and the held op after it
    assign holdLoad = cmdStart;
    assign aluOp    = (state == stIdle) ? decodedOp : cmdOp;

    // writeback target per operation
    always_comb begin
        case (cmdOp)
            atariCorePkg::opInx, atariCorePkg::opTax: wbSel = atariCorePkg::selX;
            atariCorePkg::opIny:                      wbSel = atariCorePkg::selY;
            atariCorePkg::opNop:                      wbSel = atariCorePkg::selNone;
            default:                                  wbSel = atariCorePkg::selA;
        endcase
    end

    assign regWe  = (state == stWrite) && (wbSel != atariCorePkg::selNone);
    assign flagWe = (state == stWrite) && (cmdOp != atariCorePkg::opNop);

    // hold on edge 1, adjust on edge 2, writeback and ack on edge 3
    always_ff @(posedge phi2 or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
            cmdOp <= atariCorePkg::opNop;
            wbAck <= 1'b0;
        end else begin
            wbAck <= regAccess || (state == stWrite);
            case (state)
                stIdle: begin
                    if (cmdStart) begin
                        cmdOp <= decodedOp;
                        state <= stAdjust;
                    end
                end
                stAdjust: state <= stWrite;
                default:  state <= stIdle;
            endcase
        end
    end

    // read data follows the held address
    always_comb begin
        case (wbAdr)
            `ADR_A:  wbDatRd = regA;
            `ADR_X:  wbDatRd = regX;
            `ADR_Y:  wbDatRd = regY;
            `ADR_S:  wbDatRd = regS;
            `ADR_P:  wbDatRd = status;
            default: wbDatRd = '0;
        endcase
    end

endmodule

// File: hw/execUnit.sv
// top level of the 6502-style execution unit, a Wishbone classic slave over the datapath
`timescale 1ns/1ps
`include "atari_defs.svh"

module execUnit (
    input  logic               phi2,
    input  logic               arstN,
    input  logic               wbCyc,
    input  logic               wbStb,
    input  logic               wbWe,
    input  logic [2:0]         wbAdr,
    input  logic [`DATA_W-1:0] wbDatWr,
    output logic [`DATA_W-1:0] wbDatRd,
    output logic               wbAck
);

    logic [`DATA_W-1:0]      regA;
    logic [`DATA_W-1:0]      regX;
    logic [`DATA_W-1:0]      regY;
    logic [`DATA_W-1:0]      regS;
    logic [`DATA_W-1:0]      status;
    logic [`DATA_W-1:0]      aluA;
    logic [`DATA_W-1:0]      opnd;
    logic                    opndLoad;
    logic                    holdLoad;
    logic                    regWe;
    logic                    flagWe;
    logic                    hostWe;
    logic [2:0]              hostRegSel;
    atariCorePkg::opT        aluOp;
    atariCorePkg::opT        cmdOp;
    atariCorePkg::regSelT    wbSel;
    atariCorePkg::aluResultT aluOut;
    atariCorePkg::aluResultT held;
    atariCorePkg::aluResultT adjusted;

    execControl control (
        .phi2(phi2), .arstN(arstN),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatWr(wbDatWr),
        .regA(regA), .regX(regX), .regY(regY), .regS(regS), .status(status),
        .wbDatRd(wbDatRd), .wbAck(wbAck),
        .opndLoad(opndLoad), .holdLoad(holdLoad), .aluOp(aluOp), .wbSel(wbSel),
        .regWe(regWe), .flagWe(flagWe), .hostRegSel(hostRegSel), .hostWe(hostWe),
        .cmdOp(cmdOp)
    );

    // operand byte written by the host
    holdLatch #(.payloadT(logic [`DATA_W-1:0])) opndLatch (
        .phi2(phi2), .arstN(arstN), .load(opndLoad), .d(wbDatWr), .q(opnd)
    );

    aluCore alu (
        .a(aluA), .b(opnd), .carryIn(status[`STATUS_C]), .aluOp(aluOp), .result(aluOut)
    );

    holdLatch #(.payloadT(atariCorePkg::aluResultT)) addHold (
        .phi2(phi2), .arstN(arstN), .load(holdLoad), .d(aluOut), .q(held)
    );

    // D flag turns on BCD correction
    decimalAdjust adjust (
        .phi2(phi2), .arstN(arstN), .held(held), .aluOp(cmdOp),
        .decimalEn(status[`STATUS_D]), .adjusted(adjusted)
    );

    regBank regs (
        .phi2(phi2), .arstN(arstN), .aluOp(aluOp), .wbSel(wbSel), .regWe(regWe),
        .wbValue(adjusted.value), .hostRegSel(hostRegSel), .hostWe(hostWe),
        .hostData(wbDatWr), .aluA(aluA),
        .regA(regA), .regX(regX), .regY(regY), .regS(regS)
    );

    statusReg pReg (
        .phi2(phi2), .arstN(arstN), .flagWe(flagWe), .aluOp(cmdOp), .adjusted(adjusted),
        .hostWe(hostWe), .hostSel(hostRegSel), .hostData(wbDatWr), .status(status)
    );

endmodule

// File: bench/execUnit_assert.sv
// Wishbone handshake and P read checks, bound into the execution unit top level
`timescale 1ns/1ps
`include "atari_defs.svh"

module execUnit_assert (
    input logic               phi2,
    input logic               arstN,
    input logic               wbCyc,
    input logic               wbStb,
    input logic               wbWe,
    input logic [2:0]         wbAdr,
    input logic [`DATA_W-1:0] wbDatRd,
    input logic               wbAck
);

    // ack only answers a live strobe
    ackInCycle: assert property (@(posedge phi2) disable iff (!arstN)
        wbAck |-> (wbCyc && wbStb))
        else $error("ack raised outside a Wishbone cycle");

    // ack is a single cycle pulse
    ackOnePulse: assert property (@(posedge phi2) disable iff (!arstN)
        wbAck |=> !wbAck)
        else $error("ack held for two cycles");

    // bit 5 of P always reads as one
    statusBit5: assert property (@(posedge phi2) disable iff (!arstN)
        (wbAck && !wbWe && wbAdr == `ADR_P) |-> wbDatRd[5])
        else $error("P read with bit 5 clear");

endmodule

bind execUnit execUnit_assert checks (
    .phi2(phi2), .arstN(arstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
    .wbAdr(wbAdr), .wbDatRd(wbDatRd), .wbAck(wbAck)
);

// File: bench/execUnit_tb.sv
// directed testbench that drives Wishbone cycles into the execution unit and checks registers and flags
`timescale 1ns/1ps
`include "atari_defs.svh"

module execUnit_tb;

    logic               phi2;
    logic               arstN;
    logic               wbCyc;
    logic               wbStb;
    logic               wbWe;
    logic [2:0]         wbAdr;
    logic [`DATA_W-1:0] wbDatWr;
    logic [`DATA_W-1:0] wbDatRd;
    logic               wbAck;
    // xorshift state
    logic [31:0]        rngState;

    execUnit dut (
        .phi2(phi2), .arstN(arstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatWr(wbDatWr), .wbDatRd(wbDatRd), .wbAck(wbAck)
    );

    // 8 ns clock
    initial begin
        phi2 = 1'b0;
        forever #4 phi2 = ~phi2;
    end

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkByte(input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] exp,
                             input string what);
        if (got !== exp) begin
            reportFailure($sformatf("Fail at %0t: %s expected %02h got %02h",
                                    $time, what, exp, got));
        end
    endtask

    // names the flags that differ
    task automatic checkStatus(input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] exp,
                               input string what);
        string names;
        if (got !== exp) begin
            names = "";
            if (got[`STATUS_N] !== exp[`STATUS_N]) names = {names, " N"};
            if (got[`STATUS_V] !== exp[`STATUS_V]) names = {names, " V"};
            if (got[`STATUS_B] !== exp[`STATUS_B]) names = {names, " B"};
            if (got[`STATUS_D] !== exp[`STATUS_D]) names = {names, " D"};
            if (got[`STATUS_I] !== exp[`STATUS_I]) names = {names, " I"};
            if (got[`STATUS_Z] !== exp[`STATUS_Z]) names = {names, " Z"};
            if (got[`STATUS_C] !== exp[`STATUS_C]) names = {names, " C"};
            reportFailure($sformatf("Fail at %0t: %s expected P %02h got %02h, flags%s",
                                    $time, what, exp, got, names));
        end
    endtask

    task automatic checkLatency(input int got, input int exp, input string what);
        if (got != exp) begin
            reportFailure($sformatf("Fail at %0t: %s after %0d cycles, expected %0d",
                                    $time, what, got, exp));
        end
    endtask

    // one classic write with ack sampled on the falling edge
    task automatic wbWrite(input logic [2:0] adr, input logic [`DATA_W-1:0] data);
        int waited;
        waited = 0;
        @(posedge phi2);
        wbCyc   <= 1'b1;
        wbStb   <= 1'b1;
        wbWe    <= 1'b1;
        wbAdr   <= adr;
        wbDatWr <= data;
        @(negedge phi2);
        while (!wbAck) begin
            waited++;
            if (waited > 10) begin
                reportFailure($sformatf("no ack for a write to address %0d in 10 cycles", adr));
            end
            @(negedge phi2);
        end
        @(posedge phi2);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe  <= 1'b0;
        // commands take three cycles and everything else one
        checkLatency(waited, (adr == `ADR_CMD) ? 3 : 1, "write ack");
    endtask

    task automatic wbRead(input logic [2:0] adr, output logic [`DATA_W-1:0] data);
        int waited;
        waited = 0;
        @(posedge phi2);
        wbCyc <= 1'b1;
        wbStb <= 1'b1;
        wbWe  <= 1'b0;
        wbAdr <= adr;
        @(negedge phi2);
        while (!wbAck) begin
            waited++;
            if (waited > 10) begin
                reportFailure($sformatf("no ack for a read of address %0d in 10 cycles", adr));
            end
            @(negedge phi2);
        end
        // read data is valid while ack is high
        data = wbDatRd;
        @(posedge phi2);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        checkLatency(waited, 1, "read ack");
    endtask

    task automatic readExpect(input logic [2:0] adr, input logic [`DATA_W-1:0] exp,
                              input string what);
        logic [`DATA_W-1:0] got;
        wbRead(adr, got);
        checkByte(got, exp, what);
    endtask

    task automatic readExpectStatus(input logic [`DATA_W-1:0] exp, input string what);
        logic [`DATA_W-1:0] got;
        wbRead(`ADR_P, got);
        checkStatus(got, exp, what);
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic randByte(output logic [7:0] v);
        rngState = xorshift(rngState);
        v = rngState[15:8];
    endtask

    function automatic int fromBcd(input logic [7:0] v);
        return 10 * int'(v[7:4]) + int'(v[3:0]);
    endfunction

    function automatic logic [7:0] toBcd(input int n);
        logic [3:0] tens;
        logic [3:0] ones;
        tens = 4'(n / 10);
        ones = 4'(n % 10);
        return {tens, ones};
    endfunction

    function automatic logic [7:0] cmdByte(input atariCorePkg::opT op);
        return {4'h0, op};
    endfunction

    // binary sum with C and V or a decimal sum of the two BCD numbers
    task automatic arithModel(input logic [7:0] a, input logic [7:0] b, input logic cIn,
                              input logic sub, input logic dec,
                              output logic [7:0] res, output logic cOut, output logic vOut);
        logic [7:0] bEff;
        logic [8:0] sum;
        int         dr;
        int         sv;
        bEff = sub ? ~b : b;
        sum  = {1'b0, a} + {1'b0, bEff} + {8'd0, cIn};
        res  = sum[7:0];
        cOut = sum[8];
        // V flags a signed result outside -128 to 127 in both modes
        if (sub) begin
            sv = int'($signed(a)) - int'($signed(b)) - (cIn ? 0 : 1);
        end else begin
            sv = int'($signed(a)) + int'($signed(b)) + (cIn ? 1 : 0);
        end
        vOut = (sv > 127) || (sv < -128);
        if (dec) begin
            if (sub) begin
                dr   = fromBcd(a) - fromBcd(b) - (cIn ? 0 : 1);
                cOut = (dr >= 0);
            end else begin
                dr   = fromBcd(a) + fromBcd(b) + int'(cIn);
                cOut = (dr >= 100);
            end
            if (dr < 0) begin
                dr = dr + 100;
            end
            res = toBcd(dr % 100);
        end
    endtask

    task automatic runArith(input logic [7:0] a, input logic [7:0] b, input logic cIn,
                            input logic sub, input logic dec);
        logic [7:0] pIn;
        logic [7:0] res;
        logic [7:0] expP;
        logic       cOut;
        logic       vOut;
        string      name;
        pIn = 8'h00;
        pIn[`STATUS_D] = dec;
        pIn[`STATUS_C] = cIn;
        name = sub ? "SBC" : "ADC";
        wbWrite(`ADR_P, pIn);
        wbWrite(`ADR_A, a);
        wbWrite(`ADR_OPND, b);
        wbWrite(`ADR_CMD, sub ? cmdByte(atariCorePkg::opSbc) : cmdByte(atariCorePkg::opAdc));
        arithModel(a, b, cIn, sub, dec, res, cOut, vOut);
        expP = pIn | 8'h30;
        expP[`STATUS_N] = res[7];
        expP[`STATUS_V] = vOut;
        expP[`STATUS_Z] = (res == 8'h00);
        expP[`STATUS_C] = cOut;
        readExpect(`ADR_A, res, $sformatf("%s %02h %02h c%0d A", name, a, b, cIn));
        readExpectStatus(expP, $sformatf("%s %02h %02h c%0d P", name, a, b, cIn));
    endtask

    // logic ops keep V and only LSR touches C
    task automatic runLogic(input atariCorePkg::opT op, input logic [7:0] a,
                            input logic [7:0] b, input logic cIn, input logic vIn);
        logic [7:0] pIn;
        logic [7:0] res;
        logic [7:0] expP;
        pIn = 8'h00;
        pIn[`STATUS_C] = cIn;
        pIn[`STATUS_V] = vIn;
        wbWrite(`ADR_P, pIn);
        wbWrite(`ADR_A, a);
        wbWrite(`ADR_OPND, b);
        wbWrite(`ADR_CMD, cmdByte(op));
        expP = pIn | 8'h30;
        case (op)
            atariCorePkg::opAnd: res = a & b;
            atariCorePkg::opOra: res = a | b;
            atariCorePkg::opEor: res = a ^ b;
            default: begin
                res = a >> 1;
                expP[`STATUS_C] = a[0];
            end
        endcase
        expP[`STATUS_N] = res[7];
        expP[`STATUS_Z] = (res == 8'h00);
        readExpect(`ADR_A, res, $sformatf("logic op %0d on %02h %02h A", op, a, b));
        readExpectStatus(expP, $sformatf("logic op %0d on %02h %02h P", op, a, b));
    endtask

    task automatic testResetAndHost();
        readExpect(`ADR_A, 8'h00, "A after reset");
        readExpect(`ADR_X, 8'h00, "X after reset");
        readExpect(`ADR_Y, 8'h00, "Y after reset");
        readExpect(`ADR_S, 8'hff, "S after reset");
        readExpectStatus(8'h34, "P after reset");
        wbWrite(`ADR_A, 8'h5a);
        wbWrite(`ADR_X, 8'ha5);
        wbWrite(`ADR_Y, 8'h3c);
        wbWrite(`ADR_S, 8'hc3);
        readExpect(`ADR_A, 8'h5a, "A host write");
        readExpect(`ADR_X, 8'ha5, "X host write");
        readExpect(`ADR_Y, 8'h3c, "Y host write");
        readExpect(`ADR_S, 8'hc3, "S host write");
        // bits 5 and 4 read as one whatever is written
        wbWrite(`ADR_P, 8'hcf);
        readExpectStatus(8'hff, "P host write");
        wbWrite(`ADR_P, 8'h00);
        readExpectStatus(8'h30, "P host clear");
    endtask

    task automatic testBinary();
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] r;
        for (int i = 0; i < 50; i++) begin
            randByte(a);
            randByte(b);
            randByte(r);
            runArith(a, b, r[0], 1'b0, 1'b0);
            runArith(a, b, r[1], 1'b1, 1'b0);
        end
    endtask

    task automatic testDecimal();
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] r;
        // carry out of 99 and borrow below 00
        runArith(8'h99, 8'h01, 1'b0, 1'b0, 1'b1);
        runArith(8'h00, 8'h01, 1'b1, 1'b1, 1'b1);
        for (int i = 0; i < 20; i++) begin
            randByte(r);
            a = toBcd(int'(r) % 100);
            randByte(r);
            b = toBcd(int'(r) % 100);
            randByte(r);
            runArith(a, b, r[0], 1'b0, 1'b1);
            runArith(a, b, r[1], 1'b1, 1'b1);
        end
    endtask

    task automatic testLogic();
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] r;
        for (int i = 0; i < 20; i++) begin
            randByte(a);
            randByte(b);
            randByte(r);
            runLogic(atariCorePkg::opAnd, a, b, r[0], r[1]);
            runLogic(atariCorePkg::opOra, a, b, r[2], r[3]);
            runLogic(atariCorePkg::opEor, a, b, r[4], r[5]);
            runLogic(atariCorePkg::opLsr, a, b, r[6], r[7]);
        end
    endtask

    // C preset stays through increments and transfers
    task automatic testIncTransfer();
        wbWrite(`ADR_P, 8'h01);
        wbWrite(`ADR_X, 8'hff);
        wbWrite(`ADR_CMD, cmdByte(atariCorePkg::opInx));
        readExpect(`ADR_X, 8'h00, "INX wrap");
        readExpectStatus(8'h33, "INX flags");
        wbWrite(`ADR_Y, 8'h7f);
        wbWrite(`ADR_CMD, cmdByte(atariCorePkg::opIny));
        readExpect(`ADR_Y, 8'h80, "INY result");
        readExpectStatus(8'hb1, "INY flags");
        wbWrite(`ADR_A, 8'h85);
        wbWrite(`ADR_X, 8'h11);
        wbWrite(`ADR_CMD, cmdByte(atariCorePkg::opTax));
        readExpect(`ADR_X, 8'h85, "TAX result");
        readExpect(`ADR_A, 8'h85, "A after TAX");
        readExpectStatus(8'hb1, "TAX flags");
        wbWrite(`ADR_X, 8'h00);
        wbWrite(`ADR_CMD, cmdByte(atariCorePkg::opTxa));
        readExpect(`ADR_A, 8'h00, "TXA result");
        readExpectStatus(8'h33, "TXA flags");
    endtask

    task automatic testUndefined();
        wbWrite(`ADR_A, 8'h12);
        wbWrite(`ADR_X, 8'h34);
        wbWrite(`ADR_Y, 8'h56);
        wbWrite(`ADR_S, 8'h78);
        wbWrite(`ADR_P, 8'hc9);
        // codes above 9 still ack after three cycles
        wbWrite(`ADR_CMD, 8'h3c);
        wbWrite(`ADR_CMD, 8'h0a);
        readExpect(`ADR_A, 8'h12, "A after undefined command");
        readExpect(`ADR_X, 8'h34, "X after undefined command");
        readExpect(`ADR_Y, 8'h56, "Y after undefined command");
        readExpect(`ADR_S, 8'h78, "S after undefined command");
        readExpectStatus(8'hf9, "P after undefined command");
    endtask

    initial begin
        arstN    = 1'b0;
        wbCyc    = 1'b0;
        wbStb    = 1'b0;
        wbWe     = 1'b0;
        wbAdr    = 3'd0;
        wbDatWr  = 8'h00;
        rngState = 32'd32;
        repeat (16) @(posedge phi2);
        arstN <= 1'b1;
        testResetAndHost();
        testBinary();
        testDecimal();
        testLogic();
        testIncTransfer();
        testUndefined();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: execUnit.f
+incdir+include
hw/atariCorePkg.sv
hw/holdLatch.sv
hw/aluCore.sv
hw/decimalAdjust.sv
hw/regBank.sv
hw/statusReg.sv
hw/execControl.sv
hw/execUnit.sv
bench/execUnit_assert.sv
bench/execUnit_tb.sv

// File: Makefile
VERILATOR  := verilator
TOP        := execUnit_tb
FILELIST   := execUnit.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --assert
OBJ_DIR    := obj_dir
PASS_MSG   := Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
